// ==== Makefile ====
VERILATOR ?= verilator
TOP       := hawk_rd_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the simulator output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
src/hawk_pkg.sv
src/cpu_stall_rd.sv
src/att_lookup.sv
src/rd_resp_track.sv
src/hawk_rd_top.sv
test/tb_clk_gen.sv
test/hawk_rd_tb.sv

// ==== src/att_lookup.sv ====
// ----------------------------------------------------------------------------
// address translation table lookup
// maps host pages to device pages, reports misses and counts hits/misses
// ----------------------------------------------------------------------------

module att_lookup (
    input  logic                         clk,
    input  logic                         rst,

    // request from the stall bridge and its answer
    input  hawk_pkg::cpu_rd_reqpkt_t     cpu_rd_reqpkt,
    output hawk_pkg::att_grant_t         att_grant,

    // software side
    input  hawk_pkg::att_wr_t            att_wr,
    output logic                         att_miss,
    output logic [hawk_pkg::page_w-1:0]  miss_hppa,
    output logic [hawk_pkg::cnt_w-1:0]   hit_cnt,
    output logic [hawk_pkg::cnt_w-1:0]   miss_cnt
);
    import hawk_pkg::*;

    att_entry_t        table_q [att_entries];
    att_state_e        state_q;
    logic [page_w-1:0] hppa_q;
    logic              armed_q;
    logic              grant_vld_q;
    logic [page_w-1:0] grant_dppa_q;
    logic              hit;
    logic [page_w-1:0] hit_dppa;
    logic              wr_match;

    // table write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < att_entries; i++) begin
                table_q[i].vld <= 1'b0;
            end
        end else if (att_wr.valid) begin
            table_q[att_wr.idx] <= '{vld: 1'b1, hppa: att_wr.hppa, dppa: att_wr.dppa};
        end
    end

    // parallel search, walking down so the lowest index wins
    always_comb begin
        hit      = 1'b0;
        hit_dppa = '0;
        for (int i = att_entries - 1; i >= 0; i--) begin
            if (table_q[i].vld && (table_q[i].hppa == hppa_q)) begin
                hit      = 1'b1;
                hit_dppa = table_q[i].dppa;
            end
        end
    end

    // write for the pending page in the same cycle
    assign wr_match = att_wr.valid && (att_wr.hppa == hppa_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= att_st_idle;
            armed_q     <= 1'b1;
            grant_vld_q <= 1'b0;
            att_miss    <= 1'b0;
            hit_cnt     <= '0;
            miss_cnt    <= '0;
        end else begin
            grant_vld_q <= 1'b0;

            // one lookup per request, rearm once the packet drops
            if (!cpu_rd_reqpkt.valid) begin
                armed_q <= 1'b1;
            end

            case (state_q)
                att_st_idle: begin
                    if (cpu_rd_reqpkt.valid && armed_q) begin
                        state_q <= att_st_lookup;
                    end
                end
                att_st_lookup: begin
                    if (hit || wr_match) begin
                        grant_vld_q <= 1'b1;
                        armed_q     <= 1'b0;
                        hit_cnt     <= hit_cnt + 1'b1;
                        state_q     <= att_st_idle;
                    end else begin
                        att_miss <= 1'b1;
                        miss_cnt <= miss_cnt + 1'b1;
                        state_q  <= att_st_miss;
                    end
                end
                att_st_miss: begin
                    // stalled until software installs the pending page
                    if (wr_match) begin
                        grant_vld_q <= 1'b1;
                        armed_q     <= 1'b0;
                        att_miss    <= 1'b0;
                        state_q     <= att_st_idle;
                    end
                end
                default: begin
                    state_q <= att_st_idle;
                end
            endcase
        end
    end

    // captured page, reported page and granted device page
    always_ff @(posedge clk) begin
        if (state_q == att_st_idle) begin
            hppa_q <= cpu_rd_reqpkt.hppa;
        end
        if (state_q == att_st_lookup) begin
            miss_hppa    <= hppa_q;
            grant_dppa_q <= hit ? hit_dppa : att_wr.dppa;
        end else if (state_q == att_st_miss) begin
            grant_dppa_q <= att_wr.dppa;
        end
    end

    assign att_grant.valid = grant_vld_q;
    assign att_grant.dppa  = grant_dppa_q;

    // a grant answers a request the bridge still holds
    a_grant_src: assert property (@(posedge clk) disable iff (rst)
        att_grant.valid |-> cpu_rd_reqpkt.valid
            && ($past(state_q) inside {att_st_lookup, att_st_miss}));

endmodule

// ==== src/cpu_stall_rd.sv ====
// ----------------------------------------------------------------------------
// CPU read stall bridge
// holds a captured AR beat until the ATT grants it, then issues the beat
// to memory with the host page replaced by the device page
// ----------------------------------------------------------------------------

module cpu_stall_rd (
    input  logic                     clk,
    input  logic                     rst,

    // CPU side read address
    input  hawk_pkg::axi_ar_t        s_ar,
    input  logic                     s_arvalid,
    output logic                     s_arready,

    // memory side read address
    output hawk_pkg::axi_ar_t        m_ar,
    output logic                     m_arvalid,
    input  logic                     m_arready,

    // ATT lookup handshake
    output hawk_pkg::cpu_rd_reqpkt_t cpu_rd_reqpkt,
    input  hawk_pkg::att_grant_t     att_grant,

    // response tracker
    input  logic                     rd_idle,
    output logic                     ar_fire,
    output logic [7:0]               issued_len
);
    import hawk_pkg::*;

    stall_state_e      state_q;
    axi_ar_t           ar_q;
    logic [page_w-1:0] dppa_q;
    logic              grant_seen_q;
    logic              s_ar_fire;
    logic              load;

    assign s_ar_fire = s_arvalid && s_arready;

    // translated beat is built once the grant is in and no burst is pending
    assign load = (state_q == stall_wait) && grant_seen_q && rd_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= stall_idle;
            s_arready    <= 1'b0;
            m_arvalid    <= 1'b0;
            grant_seen_q <= 1'b0;
        end else begin
            // grant is only a pulse, keep it until the beat is loaded
            if (att_grant.valid) begin
                grant_seen_q <= 1'b1;
            end

            case (state_q)
                stall_idle: begin
                    s_arready <= 1'b1;
                    if (s_ar_fire) begin
                        s_arready <= 1'b0;
                        state_q   <= stall_wait;
                    end
                end
                stall_wait: begin
                    if (load) begin
                        m_arvalid    <= 1'b1;
                        grant_seen_q <= 1'b0;
                        state_q      <= stall_issue;
                    end
                end
                stall_issue: begin
                    if (m_arready) begin
                        m_arvalid <= 1'b0;
                        s_arready <= 1'b1;
                        state_q   <= stall_idle;
                    end
                end
                default: begin
                    state_q <= stall_idle;
                end
            endcase
        end
    end

    // beat payload, the page field is overwritten in place on load
    always_ff @(posedge clk) begin
        if (att_grant.valid) begin
            dppa_q <= att_grant.dppa;
        end
        if (s_ar_fire) begin
            ar_q <= s_ar;
        end else if (load) begin
            ar_q.addr[page_lsb +: page_w] <= dppa_q;
        end
    end

    assign m_ar = ar_q;

    // lookup request stays up for the whole wait
    assign cpu_rd_reqpkt.valid = (state_q == stall_wait);
    assign cpu_rd_reqpkt.hppa  = ar_q.addr[page_lsb +: page_w];

    assign ar_fire    = m_arvalid && m_arready;
    assign issued_len = ar_q.len;

    // a stalled beat toward memory must not change or drop
    a_m_ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar));

endmodule

// ==== src/hawk_pkg.sv ====
// ----------------------------------------------------------------------------
// hawk read bridge shared definitions
// AXI4 read beat structs, ATT request/grant/write packets and FSM states
// ----------------------------------------------------------------------------

package hawk_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;
    localparam int id_w   = 4;

    // 4 KB pages, page number lives in address bits 59:12
    localparam int page_lsb = 12;
    localparam int page_w   = 48;

    // address translation table
    localparam int att_entries = 8;
    localparam int att_idx_w   = 3;

    // statistics counters
    localparam int cnt_w = 16;

    // one AXI4 read address beat
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic              lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
        logic [3:0]        qos;
        logic [3:0]        region;
        logic              user;
    } axi_ar_t;

    // one AXI4 read data beat
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic              user;
    } axi_r_t;

    // host page lookup request from the stall bridge
    typedef struct packed {
        logic              valid;
        logic [page_w-1:0] hppa;
    } cpu_rd_reqpkt_t;

    // lookup answer, valid is a single-cycle pulse
    typedef struct packed {
        logic              valid;
        logic [page_w-1:0] dppa;
    } att_grant_t;

    // software table write
    typedef struct packed {
        logic                 valid;
        logic [att_idx_w-1:0] idx;
        logic [page_w-1:0]    hppa;
        logic [page_w-1:0]    dppa;
    } att_wr_t;

    typedef struct packed {
        logic              vld;
        logic [page_w-1:0] hppa;
        logic [page_w-1:0] dppa;
    } att_entry_t;

    typedef enum logic [1:0] {
        stall_idle,
        stall_wait,
        stall_issue
    } stall_state_e;

    typedef enum logic [1:0] {
        att_st_idle,
        att_st_lookup,
        att_st_miss
    } att_state_e;

endpackage

// ==== src/hawk_rd_top.sv ====
// ----------------------------------------------------------------------------
// hawk read path top level
// stall bridge, ATT lookup and response tracker between CPU and memory
// ----------------------------------------------------------------------------

module hawk_rd_top (
    input  logic                         clk,
    input  logic                         rst,

    // CPU side
    input  hawk_pkg::axi_ar_t            s_ar,
    input  logic                         s_arvalid,
    output logic                         s_arready,
    output hawk_pkg::axi_r_t             s_r,
    output logic                         s_rvalid,
    input  logic                         s_rready,

    // memory side
    output hawk_pkg::axi_ar_t            m_ar,
    output logic                         m_arvalid,
    input  logic                         m_arready,
    input  hawk_pkg::axi_r_t             m_r,
    input  logic                         m_rvalid,
    output logic                         m_rready,

    // software side
    input  hawk_pkg::att_wr_t            att_wr,
    output logic                         att_miss,
    output logic [hawk_pkg::page_w-1:0]  miss_hppa,
    output logic [hawk_pkg::cnt_w-1:0]   hit_cnt,
    output logic [hawk_pkg::cnt_w-1:0]   miss_cnt,
    output logic                         resp_err,
    output logic                         len_err
);
    import hawk_pkg::*;

    cpu_rd_reqpkt_t cpu_rd_reqpkt;
    att_grant_t     att_grant;
    logic           rd_idle;
    logic           ar_fire;
    logic [7:0]     issued_len;

    cpu_stall_rd cpu_stall_rd_i (
        .clk           (clk),
        .rst           (rst),
        .s_ar          (s_ar),
        .s_arvalid     (s_arvalid),
        .s_arready     (s_arready),
        .m_ar          (m_ar),
        .m_arvalid     (m_arvalid),
        .m_arready     (m_arready),
        .cpu_rd_reqpkt (cpu_rd_reqpkt),
        .att_grant     (att_grant),
        .rd_idle       (rd_idle),
        .ar_fire       (ar_fire),
        .issued_len    (issued_len)
    );

    att_lookup att_lookup_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_rd_reqpkt (cpu_rd_reqpkt),
        .att_grant     (att_grant),
        .att_wr        (att_wr),
        .att_miss      (att_miss),
        .miss_hppa     (miss_hppa),
        .hit_cnt       (hit_cnt),
        .miss_cnt      (miss_cnt)
    );

    rd_resp_track rd_resp_track_i (
        .clk        (clk),
        .rst        (rst),
        .m_r        (m_r),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .s_r        (s_r),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .ar_fire    (ar_fire),
        .issued_len (issued_len),
        .rd_idle    (rd_idle),
        .resp_err   (resp_err),
        .len_err    (len_err)
    );

endmodule

// ==== src/rd_resp_track.sv ====
// ----------------------------------------------------------------------------
// read response tracker
// passes R beats to the CPU, tracks the one outstanding burst and flags
// response and burst length errors
// ----------------------------------------------------------------------------

module rd_resp_track (
    input  logic              clk,
    input  logic              rst,

    // memory side read data
    input  hawk_pkg::axi_r_t  m_r,
    input  logic              m_rvalid,
    output logic              m_rready,

    // CPU side read data
    output hawk_pkg::axi_r_t  s_r,
    output logic              s_rvalid,
    input  logic              s_rready,

    // issued burst from the stall bridge
    input  logic              ar_fire,
    input  logic [7:0]        issued_len,
    output logic              rd_idle,

    // sticky error flags
    output logic              resp_err,
    output logic              len_err
);
    logic [7:0] len_q;
    logic [8:0] beat_cnt_q;
    logic       r_fire;

    // straight pass-through, CPU back-pressure goes to memory as is
    assign s_r      = m_r;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;

    assign r_fire = m_rvalid && m_rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_idle  <= 1'b1;
            resp_err <= 1'b0;
            len_err  <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_idle <= 1'b0;
            end else if (r_fire && m_r.last) begin
                rd_idle <= 1'b1;
            end

            // anything but OKAY
            if (r_fire && (m_r.resp != 2'b00)) begin
                resp_err <= 1'b1;
            end

            // last must land on beat index len
            if (r_fire && m_r.last && (beat_cnt_q != {1'b0, len_q})) begin
                len_err <= 1'b1;
            end
        end
    end

    // beat index within the burst
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            len_q      <= issued_len;
            beat_cnt_q <= '0;
        end else if (r_fire) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    // memory may only answer a burst the bridge has issued
    a_no_stray_r: assert property (@(posedge clk) disable iff (rst)
        rd_idle |-> !m_rvalid);

endmodule

// ==== test/hawk_rd_tb.sv ====
// ----------------------------------------------------------------------------
// hawk read path testbench
// CPU reads through the ATT bridge against a memory responder model
// ----------------------------------------------------------------------------

module hawk_rd_tb;
    import hawk_pkg::*;

    localparam int n_rnd          = 10;
    localparam int n_reads        = 6 + n_rnd;
    localparam int timeout_cycles = 200 + n_reads * 80;
    localparam logic [3:0]  early_id = 4'ha;
    localparam logic [47:0] err_dppa = 48'h0000_0000_bad0;

    logic clk;
    logic rst;

    axi_ar_t           s_ar;
    logic              s_arvalid;
    logic              s_arready;
    axi_r_t            s_r;
    logic              s_rvalid;
    logic              s_rready;
    axi_ar_t           m_ar;
    logic              m_arvalid;
    logic              m_arready;
    axi_r_t            m_r;
    logic              m_rvalid;
    logic              m_rready;
    att_wr_t           att_wr;
    logic              att_miss;
    logic [page_w-1:0] miss_hppa;
    logic [cnt_w-1:0]  hit_cnt;
    logic [cnt_w-1:0]  miss_cnt;
    logic              resp_err;
    logic              len_err;

    integer seed = 32'he459_527c;
    int     val_errs = 0;
    int     misc_errs = 0;
    int     hits = 0;
    int     misses = 0;
    int     cycle_cnt = 0;

    // table model, mirrors every write sent to the DUT
    logic              tbl_vld [att_entries];
    logic [page_w-1:0] tbl_hppa [att_entries];
    logic [page_w-1:0] tbl_dppa [att_entries];
    logic [2:0]        next_idx;

    // expected R beats in order
    logic [63:0] exp_data_q [$];
    logic        exp_last_q [$];
    logic [1:0]  exp_resp_q [$];
    logic [3:0]  exp_id_q [$];
    logic [63:0] r_exp_data;
    logic        r_exp_last;
    logic [1:0]  r_exp_resp;
    logic [3:0]  r_exp_id;

    axi_ar_t           exp_ar;
    logic              miss_expected;
    logic [page_w-1:0] exp_miss_hppa;
    logic              m_issued;
    logic              resp_cause;
    logic              len_cause;

    // memory model state
    logic [63:0] mem_base;
    logic [3:0]  mem_id;
    logic [1:0]  mem_resp;
    int          mem_beats;
    int          mem_dly;

    tb_clk_gen tb_clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    hawk_rd_top hawk_rd_top_i (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .att_wr    (att_wr),
        .att_miss  (att_miss),
        .miss_hppa (miss_hppa),
        .hit_cnt   (hit_cnt),
        .miss_cnt  (miss_cnt),
        .resp_err  (resp_err),
        .len_err   (len_err)
    );

    // random ready stalls on both sides
    always begin
        @(posedge clk);
        #1;
        m_arready = ($random(seed) & 3) != 0;
        s_rready  = ($random(seed) & 3) != 0;
    end

    // memory responder, data is beat address plus beat index
    always begin
        @(posedge clk);
        if (!rst && m_arvalid && m_arready) begin
            mem_base  = m_ar.addr;
            mem_id    = m_ar.id;
            mem_resp  = (m_ar.addr[page_lsb +: page_w] == err_dppa) ? 2'b10 : 2'b00;
            mem_beats = m_ar.len + 1;
            // tagged id ends its burst one beat early
            if (m_ar.id == early_id && m_ar.len != 0) begin
                mem_beats = m_ar.len;
            end
            mem_dly = $random(seed) & 3;
            repeat (mem_dly) @(posedge clk);
            for (int i = 0; i < mem_beats; i++) begin
                #1;
                m_rvalid = 1'b1;
                m_r      = '{id: mem_id, data: mem_base + i, resp: mem_resp,
                             last: (i == mem_beats - 1), user: 1'b0};
                @(posedge clk);
                while (!m_rready) @(posedge clk);
            end
            #1 m_rvalid = 1'b0;
        end
    end

    // R monitor, pops expectations and records error causes
    always @(posedge clk) begin
        if (!rst && s_rvalid && s_rready) begin
            if (s_r.resp != 2'b00) resp_cause = 1'b1;
            if (s_r.last && s_r.id == early_id) len_cause = 1'b1;
            if (s_r.last) m_issued = 1'b0;
            if (exp_data_q.size() == 0) begin
                misc_errs++;
                $display("read data beat arrived with no read outstanding");
            end else begin
                void'(exp_data_q.pop_front());
                void'(exp_last_q.pop_front());
                void'(exp_resp_q.pop_front());
                void'(exp_id_q.pop_front());
            end
        end
        if (!rst && m_arvalid && m_arready) m_issued = 1'b1;
        if (exp_data_q.size() != 0) begin
            r_exp_data = exp_data_q[0];
            r_exp_last = exp_last_q[0];
            r_exp_resp = exp_resp_q[0];
            r_exp_id   = exp_id_q[0];
        end
    end

    a_xlate: assert property (@(posedge clk) disable iff (rst)
        m_arvalid |-> m_ar == exp_ar)
        else begin
            val_errs++;
            $display("ERR m_ar exp %h got %h", exp_ar, $sampled(m_ar));
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
        else begin
            misc_errs++;
            $display("m_ar changed or dropped while stalled");
        end

    a_single: assert property (@(posedge clk) disable iff (rst)
        m_issued |-> !m_arvalid)
        else begin
            misc_errs++;
            $display("new memory read issued while a burst is outstanding");
        end

    a_miss_page: assert property (@(posedge clk) disable iff (rst)
        att_miss |-> miss_hppa == exp_miss_hppa)
        else begin
            val_errs++;
            $display("ERR miss_hppa exp %h got %h", exp_miss_hppa, $sampled(miss_hppa));
        end

    a_miss_only: assert property (@(posedge clk) disable iff (rst)
        att_miss |-> miss_expected)
        else begin
            misc_errs++;
            $display("att_miss raised for a mapped page");
        end

    a_miss_stall: assert property (@(posedge clk) disable iff (rst)
        att_miss |-> !m_arvalid)
        else begin
            misc_errs++;
            $display("memory read issued during an ATT miss");
        end

    a_r_data: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && s_rready |-> s_r.data == r_exp_data)
        else begin
            val_errs++;
            $display("ERR s_r.data exp %h got %h", r_exp_data, $sampled(s_r.data));
        end

    a_r_ctrl: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && s_rready |-> s_r.last == r_exp_last && s_r.resp == r_exp_resp)
        else begin
            val_errs++;
            $display("ERR s_r.last/resp exp %h/%h got %h/%h", r_exp_last, r_exp_resp,
                     $sampled(s_r.last), $sampled(s_r.resp));
        end

    a_r_id: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && s_rready |-> s_r.id == r_exp_id)
        else begin
            val_errs++;
            $display("ERR s_r.id exp %h got %h", r_exp_id, $sampled(s_r.id));
        end

    a_resp_err_cause: assert property (@(posedge clk) disable iff (rst)
        resp_err |-> resp_cause)
        else begin
            misc_errs++;
            $display("resp_err set before any error response");
        end

    a_len_err_cause: assert property (@(posedge clk) disable iff (rst)
        len_err |-> len_cause)
        else begin
            misc_errs++;
            $display("len_err set before any short burst");
        end

    task automatic write_att(input logic [2:0] idx, input logic [47:0] hppa,
                             input logic [47:0] dppa);
        @(posedge clk);
        #1;
        att_wr = '{valid: 1'b1, idx: idx, hppa: hppa, dppa: dppa};
        tbl_vld[idx]  = 1'b1;
        tbl_hppa[idx] = hppa;
        tbl_dppa[idx] = dppa;
        @(posedge clk);
        #1 att_wr.valid = 1'b0;
    endtask

    // one CPU read, installs the page on a miss with new_dppa
    task automatic cpu_read(input logic [47:0] hppa, input logic [11:0] off,
                            input logic [7:0] len, input logic [3:0] id,
                            input logic [47:0] new_dppa);
        logic        hit;
        logic [47:0] dppa;
        logic [63:0] xaddr;
        axi_ar_t     ar;
        int          n;
        int          waited;

        hit  = 1'b0;
        dppa = new_dppa;
        // first valid entry from index 0 up holding the page
        for (int i = 0; i < att_entries; i++) begin
            if (!hit && tbl_vld[i] && tbl_hppa[i] == hppa) begin
                hit  = 1'b1;
                dppa = tbl_dppa[i];
            end
        end
        if (hit) hits++;
        else misses++;

        ar = '{id: id, addr: {4'h3, hppa, off}, len: len, size: 3'd3, burst: 2'b01,
               lock: 1'b0, cache: 4'h2, prot: 3'b010, qos: 4'h1, region: 4'h0,
               user: 1'b1};
        xaddr = {4'h3, dppa, off};
        n = (id == early_id && len != 0) ? len : len + 1;
        for (int i = 0; i < n; i++) begin
            exp_data_q.push_back(xaddr + i);
            exp_last_q.push_back(i == n - 1);
            exp_resp_q.push_back((dppa == err_dppa) ? 2'b10 : 2'b00);
            exp_id_q.push_back(id);
        end
        miss_expected = !hit;
        exp_miss_hppa = hppa;

        @(posedge clk);
        #1;
        s_ar      = ar;
        s_arvalid = 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        #1;
        s_arvalid   = 1'b0;
        exp_ar      = ar;
        exp_ar.addr = xaddr;

        if (!hit) begin
            waited = 0;
            while (!att_miss && waited < 20) begin
                @(posedge clk);
                waited++;
            end
            if (!att_miss) begin
                misc_errs++;
                $display("att_miss never rose for page %h", hppa);
            end
            // hold the miss a while before software answers
            repeat (3) @(posedge clk);
            write_att(next_idx, hppa, dppa);
            next_idx++;
            miss_expected = 1'b0;
        end
    endtask

    initial begin
        logic [1:0]  rnd_sel [n_rnd];
        logic [7:0]  rnd_len [n_rnd];
        logic [11:0] rnd_off [n_rnd];
        logic [3:0]  rnd_id [n_rnd];
        logic [47:0] page;

        s_ar          = '0;
        s_arvalid     = 1'b0;
        s_rready      = 1'b0;
        m_arready     = 1'b0;
        m_r           = '0;
        m_rvalid      = 1'b0;
        att_wr        = '0;
        exp_ar        = '0;
        miss_expected = 1'b0;
        exp_miss_hppa = '0;
        m_issued      = 1'b0;
        resp_cause    = 1'b0;
        len_cause     = 1'b0;
        r_exp_data    = '0;
        r_exp_last    = 1'b0;
        r_exp_resp    = '0;
        r_exp_id      = '0;
        next_idx      = 3'd3;
        for (int i = 0; i < att_entries; i++) begin
            tbl_vld[i]  = 1'b0;
            tbl_hppa[i] = '0;
            tbl_dppa[i] = '0;
        end
        for (int k = 0; k < n_rnd; k++) begin
            rnd_sel[k] = $random(seed);
            rnd_len[k] = $random(seed) & 7;
            rnd_off[k] = $random(seed) & 12'hff8;
            rnd_id[k]  = $random(seed) & 7;
        end

        @(negedge rst);
        write_att(3'd0, 48'h100, 48'h5000);
        write_att(3'd1, 48'h101, 48'h5001);
        write_att(3'd2, 48'h200, err_dppa);

        cpu_read(48'h100, 12'h040, 8'd3, 4'h1, 48'h0);
        cpu_read(48'h101, 12'h000, 8'd0, 4'h2, 48'h0);
        cpu_read(48'h300, 12'h100, 8'd2, 4'h3, 48'h6300);
        cpu_read(48'h300, 12'h200, 8'd1, 4'h4, 48'h0);
        cpu_read(48'h200, 12'h080, 8'd1, 4'h5, 48'h0);
        cpu_read(48'h100, 12'h0c0, 8'd3, early_id, 48'h0);

        for (int k = 0; k < n_rnd; k++) begin
            case (rnd_sel[k])
                2'd0: page = 48'h100;
                2'd1: page = 48'h101;
                2'd2: page = 48'h300;
                default: page = 48'h400 + k;
            endcase
            cpu_read(page, rnd_off[k], rnd_len[k], rnd_id[k], 48'h7000 + k);
        end

        while (exp_data_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        assert (hit_cnt == hits[cnt_w-1:0])
            else begin
                val_errs++;
                $display("ERR hit_cnt exp %h got %h", hits[cnt_w-1:0], hit_cnt);
            end
        assert (miss_cnt == misses[cnt_w-1:0])
            else begin
                val_errs++;
                $display("ERR miss_cnt exp %h got %h", misses[cnt_w-1:0], miss_cnt);
            end
        assert (resp_err)
            else begin
                misc_errs++;
                $display("resp_err not set after the error response");
            end
        assert (len_err)
            else begin
                misc_errs++;
                $display("len_err not set after the short burst");
            end

        $display("summary: %0d value errors, %0d other errors, %0d hits, %0d misses",
                 val_errs, misc_errs, hits, misses);
        if (val_errs == 0 && misc_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // run limit scaled by the number of reads
    initial begin
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, run stopped", cycle_cnt);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== test/tb_clk_gen.sv ====
// ----------------------------------------------------------------------------
// testbench clock and reset
// 8 unit clock period, reset held for the first 3 cycles
// ----------------------------------------------------------------------------

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule
